// File: v30_settings.svh
/*
 * widths and counts shared by the execution unit front end
 * data, fetch byte, physical address and register count
 */
`ifndef V30_SETTINGS_SVH
`define V30_SETTINGS_SVH

// register and data path width
`define V30_WORD_W 16

// prefetch queue delivers one byte per handshake
`define V30_BYTE_W 8

// physical address, segment * 16 + offset
`define V30_ADDR_W 20

// aw cw dw bw sp bp ix iy
`define V30_NUM_REGS 8

`endif

// File: v30_pkg.sv
/*
 * shared types of the execution unit
 * register ids, move endpoints, the move micro-op and bus commands
 */
package v30_pkg;

    // modrm style register number
    // word: aw cw dw bw sp bp ix iy
    // byte: al cl dl bl ah ch dh bh, bit 2 picks the high half of regs 0-3
    typedef logic [2:0] reg_id_t;

    // where a move takes its data from or puts it to
    typedef enum logic [2:0]
    {
        LOC_NONE  = 3'd0,
        // modrm reg field
        LOC_REG   = 3'd1,
        // modrm r/m field, register or memory
        LOC_RM    = 3'd2,
        // register in opcode bits 2:0
        LOC_OPREG = 3'd3,
        // immediate bytes, never a destination
        LOC_IMM   = 3'd4
    } mov_loc_t;

    // every supported instruction is one of these
    typedef struct packed
    {
        mov_loc_t src;
        mov_loc_t dst;
        // 1 = 16-bit move
        logic     word;
    } micro_op_t;

    // memory bus command
    typedef enum logic [1:0]
    {
        BUS_IDLE  = 2'd0,
        BUS_READ  = 2'd1,
        BUS_WRITE = 2'd2
    } bus_cmd_t;

endpackage

// File: register_file.sv
/*
 * general register file, eight 16-bit registers
 * byte-lane writes, one source read port and the address base ports
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module register_file
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   we,
    input  v30_pkg::reg_id_t       write_id,
    input  logic                   write_word,
    input  logic [`V30_WORD_W-1:0] write_data,
    input  v30_pkg::reg_id_t       src_id,
    input  logic                   src_word,
    output logic [`V30_WORD_W-1:0] src_data,
    output logic [`V30_WORD_W-1:0] base_bw,
    output logic [`V30_WORD_W-1:0] base_bp,
    output logic [`V30_WORD_W-1:0] index_ix,
    output logic [`V30_WORD_W-1:0] index_iy
);

    logic [`V30_WORD_W-1:0] regs [0:`V30_NUM_REGS-1];
    logic [`V30_WORD_W-1:0] src_half;

    // byte ids 4-7 are the high halves of registers 0-3
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `V30_NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            if (write_word)
                regs[write_id] <= write_data;
            else if (write_id[2])
                regs[{1'b0, write_id[1:0]}][15:8] <= write_data[7:0];
            else
                regs[{1'b0, write_id[1:0]}][7:0] <= write_data[7:0];
        end
    end

    // containing word of a byte register
    assign src_half = regs[{1'b0, src_id[1:0]}];

    // byte reads come back zero-extended
    assign src_data = src_word  ? regs[src_id] :
                      src_id[2] ? {8'h00, src_half[15:8]} :
                                  {8'h00, src_half[7:0]};

    // fixed ports for the address adder
    assign base_bw  = regs[3];
    assign base_bp  = regs[5];
    assign index_ix = regs[6];
    assign index_iy = regs[7];

endmodule

// File: instruction_fetch.sv
/*
 * instruction byte fetch over the prefetch req/ack link
 * opcode, modrm, displacement and immediate field registers
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module instruction_fetch
(
    input  logic                   clk,
    input  logic                   reset,
    output logic                   fetch_req,
    input  logic                   fetch_ack,
    input  logic [`V30_BYTE_W-1:0] fetch_data,
    input  logic                   need_modrm,
    input  logic                   need_disp,
    input  logic                   disp_word,
    input  logic                   need_imm,
    input  logic                   imm_word,
    input  logic                   instruction_done,
    output logic [7:0]             opcode,
    output logic [7:0]             modrm,
    output logic [`V30_WORD_W-1:0] disp,
    output logic [`V30_WORD_W-1:0] imm,
    output logic                   exec_start
);

    typedef enum logic [2:0]
    {
        S_OPCODE,
        S_MODRM,
        S_DISP_LO,
        S_DISP_HI,
        S_IMM_LO,
        S_IMM_HI,
        S_EXEC
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;
    logic [7:0]   opcode_q;
    logic [7:0]   modrm_q;
    logic         byte_taken;

    // the decoder sees the byte while it is on the link, so the step after
    // it is known in the capture cycle
    assign opcode = (state == S_OPCODE) ? fetch_data : opcode_q;
    assign modrm  = (state == S_MODRM)  ? fetch_data : modrm_q;

    // req only rises in a fetch step, so ack with req is a byte
    assign byte_taken = fetch_req && fetch_ack;

    always_comb
    begin
        case (state)
            S_OPCODE:  next_state = need_modrm ? S_MODRM : (need_imm ? S_IMM_LO : S_EXEC);
            S_MODRM:   next_state = need_disp ? S_DISP_LO : (need_imm ? S_IMM_LO : S_EXEC);
            S_DISP_LO: next_state = disp_word ? S_DISP_HI : (need_imm ? S_IMM_LO : S_EXEC);
            S_DISP_HI: next_state = need_imm ? S_IMM_LO : S_EXEC;
            S_IMM_LO:  next_state = imm_word ? S_IMM_HI : S_EXEC;
            default:   next_state = S_EXEC;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= S_OPCODE;
            fetch_req  <= 1'b0;
            exec_start <= 1'b0;
        end
        else
        begin
            exec_start <= 1'b0;
            if (byte_taken)
            begin
                // drop req, the queue then drops ack
                fetch_req  <= 1'b0;
                state      <= next_state;
                exec_start <= (next_state == S_EXEC);
            end
            else if (state == S_EXEC)
            begin
                // hold until the move has finished
                if (instruction_done)
                    state <= S_OPCODE;
            end
            else if (!fetch_req && !fetch_ack)
            begin
                // ack of the last byte must be low first
                fetch_req <= 1'b1;
            end
        end
    end

    // field registers
    always_ff @(posedge clk)
    begin
        if (byte_taken)
        begin
            case (state)
                S_OPCODE:  opcode_q   <= fetch_data;
                S_MODRM:   modrm_q    <= fetch_data;
                // 8-bit displacement is signed
                S_DISP_LO: disp       <= {{8{fetch_data[7]}}, fetch_data};
                S_DISP_HI: disp[15:8] <= fetch_data;
                // 8-bit immediate is zero-extended
                S_IMM_LO:  imm        <= {8'h00, fetch_data};
                S_IMM_HI:  imm[15:8]  <= fetch_data;
                default:   ;
            endcase
        end
    end

endmodule

// File: opcode_decoder.sv
/*
 * opcode and modrm translation for the mov group
 * instruction length needs and the move micro-op
 */
`timescale 1ns/1ps

module opcode_decoder
(
    input  logic                [7:0] opcode,
    input  logic                [7:0] modrm,
    output logic                      need_modrm,
    output logic                      need_disp,
    output logic                      disp_word,
    output logic                      need_imm,
    output logic                      imm_word,
    output v30_pkg::micro_op_t        micro_op
);

    logic [1:0] mode;
    logic       direct;

    assign mode = modrm[7:6];

    // mod 0 rm 6 is a bare 16-bit address
    assign direct = (mode == 2'b00) && (modrm[2:0] == 3'd6);

    always_comb
    begin
        need_modrm    = 1'b0;
        need_imm      = 1'b0;
        imm_word      = 1'b0;
        micro_op.src  = v30_pkg::LOC_NONE;
        micro_op.dst  = v30_pkg::LOC_NONE;
        micro_op.word = 1'b0;

        if (opcode[7:2] == 6'b100010)
        begin
            // 88-8b, bit 1 is the direction, bit 0 the width
            need_modrm    = 1'b1;
            micro_op.word = opcode[0];
            if (opcode[1])
            begin
                micro_op.src = v30_pkg::LOC_RM;
                micro_op.dst = v30_pkg::LOC_REG;
            end
            else
            begin
                micro_op.src = v30_pkg::LOC_REG;
                micro_op.dst = v30_pkg::LOC_RM;
            end
        end
        else if (opcode[7:4] == 4'hb)
        begin
            // b0-bf, register in bits 2:0, width in bit 3
            need_imm      = 1'b1;
            imm_word      = opcode[3];
            micro_op.src  = v30_pkg::LOC_IMM;
            micro_op.dst  = v30_pkg::LOC_OPREG;
            micro_op.word = opcode[3];
        end
        // anything else runs as a one-byte no-op
    end

    // mod 1 takes one byte, mod 2 and the direct form take two
    assign need_disp = need_modrm && ((mode == 2'b01) || (mode == 2'b10) || direct);
    assign disp_word = (mode == 2'b10) || direct;

endmodule

// File: effective_address.sv
/*
 * modrm addressing modes and physical address
 * base/index sum, displacement, ds/ss segment choice
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module effective_address
(
    input  logic [7:0]             modrm,
    input  logic [`V30_WORD_W-1:0] disp,
    input  logic [`V30_WORD_W-1:0] base_bw,
    input  logic [`V30_WORD_W-1:0] base_bp,
    input  logic [`V30_WORD_W-1:0] index_ix,
    input  logic [`V30_WORD_W-1:0] index_iy,
    input  logic [`V30_WORD_W-1:0] ds,
    input  logic [`V30_WORD_W-1:0] ss,
    output logic [`V30_ADDR_W-1:0] phys_addr,
    output logic                   mem_operand
);

    logic [1:0]             mode;
    logic [2:0]             rm;
    logic                   direct;
    logic [`V30_WORD_W-1:0] base_sum;
    logic [`V30_WORD_W-1:0] offset;
    logic [`V30_WORD_W-1:0] segment;

    assign mode   = modrm[7:6];
    assign rm     = modrm[2:0];
    assign direct = (mode == 2'b00) && (rm == 3'd6);

    // register part of the address, sums wrap at 16 bits
    always_comb
    begin
        case (rm)
            3'd0:    base_sum = base_bw + index_ix;
            3'd1:    base_sum = base_bw + index_iy;
            3'd2:    base_sum = base_bp + index_ix;
            3'd3:    base_sum = base_bp + index_iy;
            3'd4:    base_sum = index_ix;
            3'd5:    base_sum = index_iy;
            3'd6:    base_sum = base_bp;
            default: base_sum = base_bw;
        endcase
    end

    // disp is already sign-extended by the fetch unit
    assign offset = direct ? disp :
                    ((mode == 2'b01) || (mode == 2'b10)) ? base_sum + disp : base_sum;

    // bp based forms go through ss
    assign segment = ((rm == 3'd2) || (rm == 3'd3) || ((rm == 3'd6) && !direct)) ? ss : ds;

    // carry out of bit 19 is dropped
    assign phys_addr = {segment, 4'h0} + {4'h0, offset};

    assign mem_operand = (mode != 2'b11);

endmodule

// File: mov_executor.sv
/*
 * move execution
 * register file access, memory command/done bus, completion pulse
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module mov_executor
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   exec_start,
    input  v30_pkg::micro_op_t     micro_op,
    input  logic [7:0]             opcode,
    input  logic [7:0]             modrm,
    input  logic [`V30_WORD_W-1:0] imm,
    input  logic                   mem_operand,
    input  logic [`V30_ADDR_W-1:0] phys_addr,
    input  logic [`V30_WORD_W-1:0] src_data,
    output v30_pkg::reg_id_t       src_id,
    output logic                   src_word,
    output logic                   we,
    output v30_pkg::reg_id_t       write_id,
    output logic                   write_word,
    output logic [`V30_WORD_W-1:0] write_data,
    output v30_pkg::bus_cmd_t      bus_command,
    output logic [`V30_ADDR_W-1:0] bus_address,
    output logic                   bus_word,
    output logic [`V30_WORD_W-1:0] data_out,
    input  logic [`V30_WORD_W-1:0] data_in,
    input  logic                   bus_command_done,
    output logic                   instruction_done
);

    logic                   src_is_mem;
    logic                   dst_is_mem;
    logic                   dst_is_reg;
    logic                   bus_busy;
    logic [`V30_WORD_W-1:0] move_data;

    // endpoint to register number
    function automatic v30_pkg::reg_id_t loc_to_id(input v30_pkg::mov_loc_t loc,
                                                    input logic [7:0] op,
                                                    input logic [7:0] mrm);
        case (loc)
            v30_pkg::LOC_REG:   return mrm[5:3];
            v30_pkg::LOC_RM:    return mrm[2:0];
            v30_pkg::LOC_OPREG: return op[2:0];
            default:            return 3'd0;
        endcase
    endfunction

    // r/m is memory unless mod is 3
    assign src_is_mem = (micro_op.src == v30_pkg::LOC_RM) && mem_operand;
    assign dst_is_mem = (micro_op.dst == v30_pkg::LOC_RM) && mem_operand;
    assign dst_is_reg = (micro_op.dst != v30_pkg::LOC_NONE) && !dst_is_mem;

    // a bus cycle is open while the command is not idle
    assign bus_busy = (bus_command != v30_pkg::BUS_IDLE);

    // opcode and modrm stay put until instruction_done, so ids need no latch
    assign src_id     = loc_to_id(micro_op.src, opcode, modrm);
    assign src_word   = micro_op.word;
    assign write_id   = loc_to_id(micro_op.dst, opcode, modrm);
    assign write_word = micro_op.word;

    // byte moves only use bits 7:0 downstream
    assign move_data  = (micro_op.src == v30_pkg::LOC_IMM) ? imm : src_data;
    assign write_data = (bus_command == v30_pkg::BUS_READ) ? data_in : move_data;

    // register or immediate source writes in the start cycle
    // memory source writes in the done cycle of the read
    assign we = (exec_start && !bus_busy && dst_is_reg && !src_is_mem)
             || ((bus_command == v30_pkg::BUS_READ) && bus_command_done);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            bus_command      <= v30_pkg::BUS_IDLE;
            instruction_done <= 1'b0;
        end
        else
        begin
            instruction_done <= 1'b0;
            if (bus_busy)
            begin
                // command held until done is seen
                if (bus_command_done)
                begin
                    bus_command      <= v30_pkg::BUS_IDLE;
                    instruction_done <= 1'b1;
                end
            end
            else if (exec_start)
            begin
                if (src_is_mem)
                    bus_command <= v30_pkg::BUS_READ;
                else if (dst_is_mem)
                    bus_command <= v30_pkg::BUS_WRITE;
                else
                    // register moves and no-ops
                    instruction_done <= 1'b1;
            end
        end
    end

    // address, width and store data captured with the command
    always_ff @(posedge clk)
    begin
        if (exec_start && !bus_busy)
        begin
            bus_address <= phys_addr;
            bus_word    <= micro_op.word;
            data_out    <= move_data;
        end
    end

endmodule

// File: v30_execution_unit.sv
/*
 * execution unit front end top level
 * fetch, decode, address and move blocks around the register file
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module v30_execution_unit
(
    input  logic                   clk,
    input  logic                   reset,
    // prefetch queue link
    output logic                   fetch_req,
    input  logic                   fetch_ack,
    input  logic [`V30_BYTE_W-1:0] fetch_data,
    // memory bus
    output v30_pkg::bus_cmd_t      bus_command,
    output logic [`V30_ADDR_W-1:0] bus_address,
    output logic                   bus_word,
    output logic [`V30_WORD_W-1:0] data_out,
    input  logic [`V30_WORD_W-1:0] data_in,
    input  logic                   bus_command_done,
    // segments, static for now
    input  logic [`V30_WORD_W-1:0] ds,
    input  logic [`V30_WORD_W-1:0] ss,
    output logic                   instruction_done
);

    logic                   need_modrm;
    logic                   need_disp;
    logic                   disp_word;
    logic                   need_imm;
    logic                   imm_word;
    logic [7:0]             opcode;
    logic [7:0]             modrm;
    logic [`V30_WORD_W-1:0] disp;
    logic [`V30_WORD_W-1:0] imm;
    logic                   exec_start;
    v30_pkg::micro_op_t     micro_op;
    logic [`V30_ADDR_W-1:0] phys_addr;
    logic                   mem_operand;
    logic [`V30_WORD_W-1:0] base_bw;
    logic [`V30_WORD_W-1:0] base_bp;
    logic [`V30_WORD_W-1:0] index_ix;
    logic [`V30_WORD_W-1:0] index_iy;
    v30_pkg::reg_id_t       src_id;
    logic                   src_word;
    logic [`V30_WORD_W-1:0] src_data;
    logic                   we;
    v30_pkg::reg_id_t       write_id;
    logic                   write_word;
    logic [`V30_WORD_W-1:0] write_data;

    instruction_fetch u_instruction_fetch
    (
        .clk(clk), .reset(reset),
        .fetch_req(fetch_req), .fetch_ack(fetch_ack), .fetch_data(fetch_data),
        .need_modrm(need_modrm), .need_disp(need_disp), .disp_word(disp_word),
        .need_imm(need_imm), .imm_word(imm_word),
        .instruction_done(instruction_done),
        .opcode(opcode), .modrm(modrm), .disp(disp), .imm(imm),
        .exec_start(exec_start)
    );

    opcode_decoder u_opcode_decoder
    (
        .opcode(opcode), .modrm(modrm),
        .need_modrm(need_modrm), .need_disp(need_disp), .disp_word(disp_word),
        .need_imm(need_imm), .imm_word(imm_word),
        .micro_op(micro_op)
    );

    effective_address u_effective_address
    (
        .modrm(modrm), .disp(disp),
        .base_bw(base_bw), .base_bp(base_bp), .index_ix(index_ix), .index_iy(index_iy),
        .ds(ds), .ss(ss),
        .phys_addr(phys_addr), .mem_operand(mem_operand)
    );

    register_file u_register_file
    (
        .clk(clk), .reset(reset),
        .we(we), .write_id(write_id), .write_word(write_word), .write_data(write_data),
        .src_id(src_id), .src_word(src_word), .src_data(src_data),
        .base_bw(base_bw), .base_bp(base_bp), .index_ix(index_ix), .index_iy(index_iy)
    );

    mov_executor u_mov_executor
    (
        .clk(clk), .reset(reset),
        .exec_start(exec_start), .micro_op(micro_op),
        .opcode(opcode), .modrm(modrm), .imm(imm),
        .mem_operand(mem_operand), .phys_addr(phys_addr),
        .src_data(src_data), .src_id(src_id), .src_word(src_word),
        .we(we), .write_id(write_id), .write_word(write_word), .write_data(write_data),
        .bus_command(bus_command), .bus_address(bus_address), .bus_word(bus_word),
        .data_out(data_out), .data_in(data_in), .bus_command_done(bus_command_done),
        .instruction_done(instruction_done)
    );

endmodule

// File: tb_execution_unit.sv
/*
 * random-stimulus testbench of the execution unit front end
 * register and memory model, prefetch queue and memory responders, checks
 */
`timescale 1ns/1ps
`include "v30_settings.svh"

module tb_execution_unit;

    localparam int N_IMM       = 16;
    localparam int N_LOAD      = 24;
    localparam int N_MOVE      = 16;
    localparam int N_UNDEF     = 8;
    localparam int N_MIX       = 48;
    localparam int TOTAL_INSTR = 8 + 2 * (N_IMM + N_LOAD + N_MOVE + N_UNDEF) + N_MIX;
    // 40 cycles per instruction, a few more for reset
    localparam int WATCHDOG_NS = (TOTAL_INSTR * 40 + 10) * 8;

    logic                   clk;
    logic                   reset;
    logic                   fetch_req;
    logic                   fetch_ack = 1'b0;
    logic [`V30_BYTE_W-1:0] fetch_data = '0;
    v30_pkg::bus_cmd_t      bus_command;
    logic [`V30_ADDR_W-1:0] bus_address;
    logic                   bus_word;
    logic [`V30_WORD_W-1:0] data_out;
    logic [`V30_WORD_W-1:0] data_in = '0;
    logic                   bus_command_done = 1'b0;
    logic [`V30_WORD_W-1:0] ds;
    logic [`V30_WORD_W-1:0] ss;
    logic                   instruction_done;

    // stimulus and responder delays draw from separate seeds
    integer stim_seed  = 32'h7066_e4e4;
    integer delay_seed = ~32'h7066_e4e4;

    // model state
    logic [15:0]        model_regs [0:7];
    logic [7:0]         mem [logic [19:0]];
    logic [7:0]         byte_q [$];
    v30_pkg::bus_cmd_t  exp_cmd = v30_pkg::BUS_IDLE;
    logic [19:0]        exp_addr;
    logic               exp_word;
    logic [15:0]        exp_data;
    int                 txn_count = 0;

    // responder state
    int          ack_wait = 0;
    int          done_wait = 0;
    logic        bus_open = 1'b0;
    logic [19:0] held_addr;
    logic [15:0] held_data;
    logic [31:0] junk;

    v30_execution_unit u_v30_execution_unit
    (
        .clk(clk), .reset(reset),
        .fetch_req(fetch_req), .fetch_ack(fetch_ack), .fetch_data(fetch_data),
        .bus_command(bus_command), .bus_address(bus_address), .bus_word(bus_word),
        .data_out(data_out), .data_in(data_in), .bus_command_done(bus_command_done),
        .ds(ds), .ss(ss), .instruction_done(instruction_done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_true(input logic ok, input string what);
        assert (ok)
        else
        begin
            $display("error: %s", what);
            stop_run();
        end
    endtask

    // untouched memory returns a pattern of the full address
    function automatic logic [7:0] mem_byte(input logic [19:0] a);
        if (mem.exists(a))
            return mem[a];
        return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]};
    endfunction

    // byte ids 4-7 are the high halves of registers 0-3
    function automatic logic [15:0] model_read(input logic [2:0] id, input logic w);
        if (w)
            return model_regs[id];
        if (id[2])
            return {8'h00, model_regs[{1'b0, id[1:0]}][15:8]};
        return {8'h00, model_regs[{1'b0, id[1:0]}][7:0]};
    endfunction

    task automatic model_write(input logic [2:0] id, input logic w, input logic [15:0] v);
        if (w)
            model_regs[id] = v;
        else if (id[2])
            model_regs[{1'b0, id[1:0]}][15:8] = v[7:0];
        else
            model_regs[{1'b0, id[1:0]}][7:0] = v[7:0];
    endtask

    // 8086 addressing, bw=3 bp=5 ix=6 iy=7, bp forms through ss
    function automatic logic [19:0] model_address(input logic [7:0] mrm, input logic [15:0] d);
        logic [15:0] ea;
        logic [15:0] seg;
        logic        direct;
        direct = (mrm[7:6] == 2'b00) && (mrm[2:0] == 3'd6);
        case (mrm[2:0])
            3'd0:    ea = model_regs[3] + model_regs[6];
            3'd1:    ea = model_regs[3] + model_regs[7];
            3'd2:    ea = model_regs[5] + model_regs[6];
            3'd3:    ea = model_regs[5] + model_regs[7];
            3'd4:    ea = model_regs[6];
            3'd5:    ea = model_regs[7];
            3'd6:    ea = model_regs[5];
            default: ea = model_regs[3];
        endcase
        if (direct)
            ea = d;
        else if (mrm[7:6] == 2'b01 || mrm[7:6] == 2'b10)
            ea = ea + d;
        if (mrm[2:0] == 3'd2 || mrm[2:0] == 3'd3 || (mrm[2:0] == 3'd6 && !direct))
            seg = ss;
        else
            seg = ds;
        return {seg, 4'h0} + {4'h0, ea};
    endfunction

    // queue one instruction, predict it, wait for instruction_done
    task automatic run_instr(input logic [7:0] op, input logic [7:0] mrm,
                             input logic [15:0] disp, input logic [15:0] imm);
        logic        w;
        logic        direct;
        logic [15:0] d;
        logic [19:0] a;
        @(posedge clk);
        w = op[0];
        direct = (mrm[7:6] == 2'b00) && (mrm[2:0] == 3'd6);
        exp_cmd = v30_pkg::BUS_IDLE;
        txn_count = 0;
        byte_q.push_back(op);
        if (op[7:2] == 6'b100010)
        begin
            byte_q.push_back(mrm);
            d = 16'h0000;
            if (mrm[7:6] == 2'b01)
            begin
                byte_q.push_back(disp[7:0]);
                d = {{8{disp[7]}}, disp[7:0]};
            end
            else if (mrm[7:6] == 2'b10 || direct)
            begin
                byte_q.push_back(disp[7:0]);
                byte_q.push_back(disp[15:8]);
                d = disp;
            end
            a = model_address(mrm, d);
            exp_addr = a;
            exp_word = w;
            if (mrm[7:6] == 2'b11)
            begin
                if (op[1])
                    model_write(mrm[5:3], w, model_read(mrm[2:0], w));
                else
                    model_write(mrm[2:0], w, model_read(mrm[5:3], w));
            end
            else if (op[1])
            begin
                // no store happens before the responder serves this read
                exp_cmd = v30_pkg::BUS_READ;
                model_write(mrm[5:3], w, {w ? mem_byte(a + 20'd1) : 8'h00, mem_byte(a)});
            end
            else
            begin
                exp_cmd = v30_pkg::BUS_WRITE;
                exp_data = model_read(mrm[5:3], w);
            end
        end
        else if (op[7:4] == 4'hb)
        begin
            byte_q.push_back(imm[7:0]);
            if (op[3])
                byte_q.push_back(imm[15:8]);
            model_write(op[2:0], op[3], op[3] ? imm : {8'h00, imm[7:0]});
        end
        @(negedge clk);
        while (!instruction_done)
            @(negedge clk);
        check_value("bus transactions", 32'(txn_count),
                    (exp_cmd == v30_pkg::BUS_IDLE) ? 32'h0 : 32'h1);
        check_true(byte_q.size() == 0, "instruction ended before all its bytes were fetched");
        @(negedge clk);
        check_value("instruction_done", 32'(instruction_done), 32'h0);
    endtask

    // direct-address store, mod 0 rm 6
    task automatic store_direct(input logic [2:0] id, input logic w);
        run_instr({7'b1000100, w}, {2'b00, id, 3'd6}, 16'($random(stim_seed)), 16'h0000);
    endtask

    task automatic pick_undefined(output logic [7:0] op);
        op = 8'($random(stim_seed));
        while (op[7:2] == 6'b100010 || op[7:4] == 4'hb)
            op = 8'($random(stim_seed));
    endtask

    // prefetch queue and memory bus, both driven on the falling edge
    always @(negedge clk)
    begin
        if (fetch_ack)
        begin
            check_true(!fetch_req, "fetch_req still high one cycle after fetch_ack");
            fetch_ack = 1'b0;
        end
        else if (fetch_req && byte_q.size() != 0)
        begin
            if (ack_wait == 0)
            begin
                fetch_data = byte_q.pop_front();
                fetch_ack = 1'b1;
                ack_wait = $unsigned($random(delay_seed)) % 4;
            end
            else
                ack_wait = ack_wait - 1;
        end

        if (bus_command_done)
        begin
            // command must be back to idle the cycle after done
            bus_command_done = 1'b0;
            check_value("bus_command", 32'(bus_command), 32'(v30_pkg::BUS_IDLE));
        end
        else if (bus_command != v30_pkg::BUS_IDLE)
        begin
            if (!bus_open)
            begin
                check_true(exp_cmd != v30_pkg::BUS_IDLE && txn_count == 0,
                           "bus command issued where the model expects none");
                check_value("bus_command", 32'(bus_command), 32'(exp_cmd));
                check_value("bus_address", 32'(bus_address), 32'(exp_addr));
                check_value("bus_word", 32'(bus_word), 32'(exp_word));
                if (bus_command == v30_pkg::BUS_WRITE)
                    check_value("data_out", exp_word ? 32'(data_out) : 32'(data_out[7:0]),
                                32'(exp_data));
                txn_count = txn_count + 1;
                bus_open = 1'b1;
                held_addr = bus_address;
                held_data = data_out;
                done_wait = $unsigned($random(delay_seed)) % 5;
            end
            else
            begin
                check_value("bus_command", 32'(bus_command), 32'(exp_cmd));
                check_value("bus_address", 32'(bus_address), 32'(held_addr));
                check_value("bus_word", 32'(bus_word), 32'(exp_word));
                if (bus_command == v30_pkg::BUS_WRITE)
                    check_value("data_out", 32'(data_out), 32'(held_data));
            end
            if (done_wait == 0)
            begin
                if (bus_command == v30_pkg::BUS_READ)
                begin
                    // upper byte of a byte read is noise
                    junk = $random(delay_seed);
                    data_in = bus_word ? {mem_byte(bus_address + 20'd1), mem_byte(bus_address)}
                                       : {junk[7:0], mem_byte(bus_address)};
                end
                else
                begin
                    mem[bus_address] = data_out[7:0];
                    if (bus_word)
                        mem[bus_address + 20'd1] = data_out[15:8];
                end
                bus_command_done = 1'b1;
                bus_open = 1'b0;
            end
            else
                done_wait = done_wait - 1;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the instruction stream did not complete in time");
        stop_run();
    end

    initial
    begin : main_sequence
        logic [7:0] op;
        logic [7:0] mrm;
        int         kind;
        reset = 1'b1;
        ds = 16'h0000;
        ss = 16'h0000;
        for (int r = 0; r < 8; r++)
            model_regs[r] = 16'h0000;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value("bus_command", 32'(bus_command), 32'(v30_pkg::BUS_IDLE));
        check_value("instruction_done", 32'(instruction_done), 32'h0);
        check_value("fetch_req", 32'(fetch_req), 32'h0);
        reset = 1'b0;
        @(negedge clk);
        check_value("fetch_req", 32'(fetch_req), 32'h1);

        // every register is zero after reset
        for (int r = 0; r < 8; r++)
            store_direct(3'(r), 1'b1);

        // immediates, then the byte or its containing word is stored
        for (int i = 0; i < N_IMM; i++)
        begin
            op = {4'hb, 4'($random(stim_seed))};
            run_instr(op, 8'h00, 16'h0000, 16'($random(stim_seed)));
            if (i[0])
                store_direct(op[2:0], op[3]);
            else
                store_direct(op[3] ? op[2:0] : {1'b0, op[1:0]}, 1'b1);
        end

        // loads over every mod and rm with fresh segments
        for (int i = 0; i < N_LOAD; i++)
        begin
            ds = 16'($random(stim_seed));
            ss = 16'($random(stim_seed));
            mrm = {2'(i % 3), 3'($random(stim_seed)), 3'(i)};
            op = {7'b1000101, 1'($random(stim_seed))};
            run_instr(op, mrm, 16'($random(stim_seed)), 16'h0000);
            store_direct(mrm[5:3], op[0]);
        end

        // register moves both ways, no bus cycle
        for (int i = 0; i < N_MOVE; i++)
        begin
            op = {6'b100010, 2'($random(stim_seed))};
            mrm = {2'b11, 6'($random(stim_seed))};
            run_instr(op, mrm, 16'h0000, 16'h0000);
            store_direct(op[1] ? mrm[5:3] : mrm[2:0], op[0]);
        end

        // one-byte no-ops followed by a store
        for (int i = 0; i < N_UNDEF; i++)
        begin
            pick_undefined(op);
            run_instr(op, 8'h00, 16'h0000, 16'h0000);
            store_direct(3'($random(stim_seed)), 1'($random(stim_seed)));
        end

        // mixed stream, kinds 1 and 3 are the mov group
        for (int i = 0; i < N_MIX; i++)
        begin
            kind = $unsigned($random(stim_seed)) % 4;
            mrm = 8'($random(stim_seed));
            case (kind)
                0:       op = {4'hb, 4'($random(stim_seed))};
                2:       pick_undefined(op);
                default: op = {6'b100010, 2'($random(stim_seed))};
            endcase
            if (kind == 3)
                mrm[7] = 1'b0;
            run_instr(op, mrm, 16'($random(stim_seed)), 16'($random(stim_seed)));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
v30_pkg.sv
register_file.sv
instruction_fetch.sv
opcode_decoder.sv
effective_address.sv
mov_executor.sv
v30_execution_unit.sv
tb_execution_unit.sv

// File: run_sim.sh
#!/bin/sh
# build the execution unit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_execution_unit -o tb_execution_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_execution_unit > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation clean"
exit 0
